//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = decoder_tb
FILELIST = decoder_top.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(shell grep -v '^+' $(FILELIST)) $(wildcard hdl/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | awk '{ print } /^all tests passed$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

//--- decoder_top.f
+incdir+hdl
hdl/decoder_pkg.sv
hdl/alu_decode.sv
hdl/mem_decode.sv
hdl/branch_decode.sv
hdl/decode_stage.sv
hdl/decoder_top.sv
verification/tb_clock_gen.sv
verification/decoder_tb.sv

//--- hdl/alu_decode.sv
`timescale 1ns/1ps
`include "decoder_params.svh"

module alu_decode
(
    input  logic [`DEC_XLEN-1:0]    ir,
    output decoder_pkg::class_dec_t res
);

    logic [`DEC_OP_W-1:0]  op;
    logic [`DEC_REG_W-1:0] rk_f;
    logic [`DEC_REG_W-1:0] rj_f;
    logic [`DEC_REG_W-1:0] rd_f;
    logic [11:0]           imm12;
    logic [19:0]           imm20;
    logic                  hit;
    decoder_pkg::decode_t  d;

    assign op    = ir[`DEC_OP_LSB +: `DEC_OP_W];
    assign rk_f  = ir[`DEC_RK_LSB +: `DEC_REG_W];
    assign rj_f  = ir[`DEC_RJ_LSB +: `DEC_REG_W];
    assign rd_f  = ir[`DEC_RD_LSB +: `DEC_REG_W];
    assign imm12 = ir[`DEC_I12_LSB +: 12];
    assign imm20 = ir[`DEC_I20_LSB +: 20];

    always_comb
    begin
        d   = '0;
        hit = 1'b0;
        case (op)
            6'b000000:
                case (ir[25:22])
                    4'b0000:   // Three register forms
                    begin
                        hit        = 1'b1;
                        d.rk       = rk_f;
                        d.rj       = rj_f;
                        d.rd       = rd_f;
                        d.regwrite = 1'b1;
                        case (ir[21:15])
                            7'b0100000: d.alu_op = decoder_pkg::ALU_ADD;
                            7'b0100010: d.alu_op = decoder_pkg::ALU_SUB;
                            7'b0100100: d.alu_op = decoder_pkg::ALU_SLT;
                            7'b0100101: d.alu_op = decoder_pkg::ALU_SLTU;
                            7'b0101000: d.alu_op = decoder_pkg::ALU_NOR;
                            7'b0101001: d.alu_op = decoder_pkg::ALU_AND;
                            7'b0101010: d.alu_op = decoder_pkg::ALU_OR;
                            7'b0101011: d.alu_op = decoder_pkg::ALU_XOR;
                            7'b0101110: d.alu_op = decoder_pkg::ALU_SLL;
                            7'b0101111: d.alu_op = decoder_pkg::ALU_SRL;
                            7'b0110000: d.alu_op = decoder_pkg::ALU_SRA;
                            7'b0111000, 7'b0111001, 7'b0111010:
                            begin
                                d.unit    = decoder_pkg::UNIT_MUL;
                                d.subtype = {2'b00, ir[16:15]};   // MUL.W, MULH.W, MULH.WU
                            end
                            7'b1000000, 7'b1000001, 7'b1000010, 7'b1000011:
                            begin
                                d.unit    = decoder_pkg::UNIT_DIV;
                                d.subtype = {2'b00, ir[16:15]};
                            end
                            7'b1010100: d = decoder_pkg::excp_dec(`DEC_EXCP_BRK);
                            7'b1010110: d = decoder_pkg::excp_dec(`DEC_EXCP_SYS);
                            default:    hit = 1'b0;
                        endcase
                    end
                    4'b0001:   // Shift by immediate
                        if (ir[21:20] == 2'b00 && ir[17:15] == 3'b001 && ir[19:18] != 2'b11)
                        begin
                            hit        = 1'b1;
                            d.imm      = {27'b0, ir[14:10]};
                            d.rj       = rj_f;
                            d.rd       = rd_f;
                            d.src2     = decoder_pkg::SRC2_IMM;
                            d.regwrite = 1'b1;
                            case (ir[19:18])
                                2'b00:   d.alu_op = decoder_pkg::ALU_SLL;
                                2'b01:   d.alu_op = decoder_pkg::ALU_SRL;
                                default: d.alu_op = decoder_pkg::ALU_SRA;
                            endcase
                        end
                    4'b1000, 4'b1001, 4'b1010, 4'b1101, 4'b1110, 4'b1111:
                    begin
                        hit        = 1'b1;
                        d.rj       = rj_f;
                        d.rd       = rd_f;
                        d.src2     = decoder_pkg::SRC2_IMM;
                        d.regwrite = 1'b1;
                        d.imm      = ir[24] ? {20'b0, imm12} : {{20{imm12[11]}}, imm12};
                        case (ir[24:22])
                            3'b000:  d.alu_op = decoder_pkg::ALU_SLT;
                            3'b001:  d.alu_op = decoder_pkg::ALU_SLTU;
                            3'b010:  d.alu_op = decoder_pkg::ALU_ADD;
                            3'b101:  d.alu_op = decoder_pkg::ALU_AND;
                            3'b110:  d.alu_op = decoder_pkg::ALU_OR;
                            default: d.alu_op = decoder_pkg::ALU_XOR;
                        endcase
                    end
                    default: hit = 1'b0;
                endcase
            6'b000101, 6'b000111:   // LU12I.W and PCADDU12I
                if (!ir[25])
                begin
                    hit        = 1'b1;
                    d.imm      = {imm20, 12'b0};
                    d.rd       = rd_f;
                    d.src2     = decoder_pkg::SRC2_IMM;
                    d.regwrite = 1'b1;
                    if (op[1])
                    begin
                        d.alu_op = decoder_pkg::ALU_ADD;
                        d.src1   = decoder_pkg::SRC1_PC;
                    end
                    else
                        d.alu_op = decoder_pkg::ALU_PASS_B;
                end
            default: hit = 1'b0;
        endcase
    end

    assign res.hit = hit;
    assign res.dec = d;

    always_comb
    begin
        assert final (!(res.hit && (res.dec.memread || res.dec.memwrite)))
            else $error("alu_decode hit with memory access");
    end

endmodule

//--- hdl/branch_decode.sv
`timescale 1ns/1ps
`include "decoder_params.svh"

module branch_decode
(
    input  logic [`DEC_XLEN-1:0]    ir,
    output decoder_pkg::class_dec_t res
);

    logic [`DEC_OP_W-1:0]  op;
    logic [`DEC_REG_W-1:0] rj_f;
    logic [`DEC_REG_W-1:0] rd_f;
    logic [`DEC_XLEN-1:0]  off16;
    logic [`DEC_XLEN-1:0]  off26;
    logic                  hit;
    decoder_pkg::decode_t  d;

    assign op    = ir[`DEC_OP_LSB +: `DEC_OP_W];
    assign rj_f  = ir[`DEC_RJ_LSB +: `DEC_REG_W];
    assign rd_f  = ir[`DEC_RD_LSB +: `DEC_REG_W];
    assign off16 = {{14{ir[25]}}, ir[25:10], 2'b00};
    assign off26 = {{4{ir[9]}}, ir[9:0], ir[25:10], 2'b00};   // offs[25:16] sits in ir[9:0]

    always_comb
    begin
        d   = '0;
        hit = 1'b1;
        case (op)
            6'b010011:   // JIRL
            begin
                d.unit     = decoder_pkg::UNIT_LINK;
                d.imm      = off16;
                d.rj       = rj_f;
                d.rd       = rd_f;
                d.regwrite = 1'b1;
                d.alu_op   = decoder_pkg::ALU_ADD;
                d.src1     = decoder_pkg::SRC1_PC;
                d.src2     = decoder_pkg::SRC2_FOUR;
                if (rd_f == 5'd0 && rj_f == 5'd1 && ir[25:10] == 16'd0)
                    d.br_kind = decoder_pkg::BR_RET;
                else if (rd_f == 5'd1)
                    d.br_kind = decoder_pkg::BR_CALL;
                else
                    d.br_kind = decoder_pkg::BR_INDIRECT;
            end
            6'b010100:   // B
            begin
                d.unit    = decoder_pkg::UNIT_BR;
                d.imm     = off26;
                d.br_kind = decoder_pkg::BR_JUMP;
            end
            6'b010101:   // BL writes the link to r1
            begin
                d.unit     = decoder_pkg::UNIT_LINK;
                d.subtype  = 4'd1;
                d.imm      = off26;
                d.rd       = 5'd1;
                d.regwrite = 1'b1;
                d.alu_op   = decoder_pkg::ALU_ADD;
                d.src1     = decoder_pkg::SRC1_PC;
                d.src2     = decoder_pkg::SRC2_FOUR;
                d.br_kind  = decoder_pkg::BR_CALL;
            end
            6'b010110, 6'b010111, 6'b011000, 6'b011001, 6'b011010, 6'b011011:
            begin
                d.unit    = decoder_pkg::UNIT_BR;
                d.imm     = off16;
                d.rj      = rj_f;
                d.rd      = rd_f;
                d.src2    = decoder_pkg::SRC2_RD;
                d.br_kind = decoder_pkg::BR_DIRECT;
                d.subtype = {1'b0, op[2:0]} + 4'd3;   // BEQ 1 through BGEU 6 with wrap
                case (op[2:1])
                    2'b11:   d.alu_op = decoder_pkg::ALU_SUB;    // BEQ, BNE
                    2'b00:   d.alu_op = decoder_pkg::ALU_SLT;
                    default: d.alu_op = decoder_pkg::ALU_SLTU;
                endcase
                d.subtype[3] = 1'b0;
            end
            default: hit = 1'b0;
        endcase
    end

    assign res.hit = hit;
    assign res.dec = d;

    always_comb
    begin
        assert final (!res.hit || res.dec.br_kind != decoder_pkg::BR_NOT_JUMP)
            else $error("branch_decode hit without a branch kind");
    end

endmodule

//--- hdl/decode_stage.sv
`timescale 1ns/1ps
`include "decoder_params.svh"

module decode_stage
(
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    in_valid,
    input  logic [`DEC_XLEN-1:0]    pc,
    input  logic [`DEC_EXCP_W-1:0]  fetch_excp,
    input  decoder_pkg::class_dec_t alu_res,
    input  decoder_pkg::class_dec_t mem_res,
    input  decoder_pkg::class_dec_t br_res,
    output logic                    out_valid,
    output decoder_pkg::decode_t    out_dec
);

    logic [`DEC_EXCP_W-1:0] fault_arg;
    decoder_pkg::decode_t   next_dec;

    // Front end code without its flag bit
    always_comb
    begin
        fault_arg                       = fetch_excp;
        fault_arg[`DEC_FETCH_FAULT_BIT] = 1'b0;
    end

    // Fetch fault, then misaligned pc, then the class decoders
    always_comb
    begin
        if (fetch_excp[`DEC_FETCH_FAULT_BIT])
            next_dec = decoder_pkg::excp_dec(fault_arg);
        else if (|pc[1:0])
            next_dec = decoder_pkg::excp_dec(`DEC_EXCP_ADEF);
        else if (alu_res.hit)
            next_dec = alu_res.dec;
        else if (mem_res.hit)
            next_dec = mem_res.dec;
        else if (br_res.hit)
            next_dec = br_res.dec;
        else
            next_dec = decoder_pkg::excp_dec(`DEC_EXCP_INE);   // Unknown or dropped encoding
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            out_valid <= 1'b0;
            out_dec   <= '0;
        end
        else
        begin
            out_valid <= in_valid;
            out_dec   <= in_valid ? next_dec : '0;   // Idle slots carry zeros
        end
    end

    // Opcode classes of the three decoders are disjoint
    assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0({alu_res.hit, mem_res.hit, br_res.hit}))
        else $error("more than one class decoder hit");

endmodule

//--- hdl/decoder_params.svh
`ifndef DECODER_PARAMS_SVH
`define DECODER_PARAMS_SVH

// Datapath and register index widths
`define DEC_XLEN            32
`define DEC_REG_W           5
`define DEC_SUB_W           4
`define DEC_EXCP_W          16

// Instruction field positions
`define DEC_OP_LSB          26
`define DEC_OP_W            6
`define DEC_RD_LSB          0
`define DEC_RJ_LSB          5
`define DEC_RK_LSB          10
`define DEC_I12_LSB         10
`define DEC_I20_LSB         5

// Exception codes, 6 bit ecode zero-extended
`define DEC_EXCP_ADEF       16'h0008
`define DEC_EXCP_SYS        16'h000B
`define DEC_EXCP_BRK        16'h000C
`define DEC_EXCP_INE        16'h000D

// Valid flag carried in the fetch fault word
`define DEC_FETCH_FAULT_BIT 15

`endif

//--- hdl/decoder_pkg.sv
`include "decoder_params.svh"

package decoder_pkg;

    typedef enum logic [3:0]
    {
        UNIT_ALU  = 4'd0,
        UNIT_BR   = 4'd1,
        UNIT_DIV  = 4'd2,
        UNIT_EXCP = 4'd3,
        UNIT_MUL  = 4'd4,
        UNIT_MEM  = 4'd5,
        UNIT_LINK = 4'd8   // ALU result plus branch
    } unit_e;

    typedef enum logic [3:0]
    {
        ALU_AND    = 4'd0,
        ALU_OR     = 4'd1,
        ALU_NOR    = 4'd2,
        ALU_XOR    = 4'd3,
        ALU_ADD    = 4'd4,
        ALU_SUB    = 4'd5,
        ALU_SLL    = 4'd6,
        ALU_SRL    = 4'd7,
        ALU_SRA    = 4'd8,
        ALU_SLT    = 4'd9,
        ALU_SLTU   = 4'd10,
        ALU_PASS_B = 4'd12
    } alu_op_e;

    // Predictor classes
    typedef enum logic [2:0]
    {
        BR_NOT_JUMP = 3'd0,
        BR_DIRECT   = 3'd1,
        BR_JUMP     = 3'd2,
        BR_CALL     = 3'd3,
        BR_RET      = 3'd4,
        BR_INDIRECT = 3'd5
    } br_kind_e;

    typedef enum logic
    {
        SRC1_REG = 1'b0,
        SRC1_PC  = 1'b1
    } src1_e;

    typedef enum logic [1:0]
    {
        SRC2_REG  = 2'd0,
        SRC2_IMM  = 2'd1,
        SRC2_RD   = 2'd2,
        SRC2_FOUR = 2'd3   // Link address
    } src2_e;

    typedef struct packed
    {
        unit_e                  unit;
        alu_op_e                alu_op;
        logic [`DEC_SUB_W-1:0]  subtype;
        logic [`DEC_REG_W-1:0]  rj;
        logic [`DEC_REG_W-1:0]  rk;
        logic [`DEC_REG_W-1:0]  rd;
        logic [`DEC_XLEN-1:0]   imm;
        src1_e                  src1;
        src2_e                  src2;
        logic                   regwrite;
        logic                   memread;
        logic                   memwrite;
        br_kind_e               br_kind;
        logic [`DEC_EXCP_W-1:0] excp_arg;
    } decode_t;

    typedef struct packed
    {
        logic    hit;
        decode_t dec;
    } class_dec_t;

    // Exception result, everything else zero
    function automatic decode_t excp_dec(input logic [`DEC_EXCP_W-1:0] arg);
        decode_t d;
        d          = '0;
        d.unit     = UNIT_EXCP;
        d.excp_arg = arg;
        return d;
    endfunction

endpackage

//--- hdl/decoder_top.sv
`timescale 1ns/1ps
`include "decoder_params.svh"

module decoder_top
(
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   in_valid,
    input  logic [`DEC_XLEN-1:0]   ir,
    input  logic [`DEC_XLEN-1:0]   pc,
    input  logic [`DEC_EXCP_W-1:0] fetch_excp,
    output logic                   out_valid,
    output decoder_pkg::decode_t   out_dec
);

    decoder_pkg::class_dec_t alu_res;
    decoder_pkg::class_dec_t mem_res;
    decoder_pkg::class_dec_t br_res;

    alu_decode u_alu_decode
    (
        .ir  (ir),
        .res (alu_res)
    );

    mem_decode u_mem_decode
    (
        .ir  (ir),
        .res (mem_res)
    );

    branch_decode u_branch_decode
    (
        .ir  (ir),
        .res (br_res)
    );

    decode_stage u_decode_stage
    (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .pc         (pc),
        .fetch_excp (fetch_excp),
        .alu_res    (alu_res),
        .mem_res    (mem_res),
        .br_res     (br_res),
        .out_valid  (out_valid),
        .out_dec    (out_dec)
    );

endmodule

//--- hdl/mem_decode.sv
`timescale 1ns/1ps
`include "decoder_params.svh"

module mem_decode
(
    input  logic [`DEC_XLEN-1:0]    ir,
    output decoder_pkg::class_dec_t res
);

    logic [11:0]          imm12;
    logic                 is_load;
    logic                 hit;
    decoder_pkg::decode_t d;

    assign imm12 = ir[`DEC_I12_LSB +: 12];

    always_comb
    begin
        d       = '0;
        hit     = 1'b0;
        is_load = 1'b0;
        if (ir[`DEC_OP_LSB +: `DEC_OP_W] == 6'b001010)
        begin
            hit = 1'b1;
            case (ir[25:22])
                4'b0000: d.subtype = 4'd0;   // LD.B
                4'b0001: d.subtype = 4'd1;
                4'b0010: d.subtype = 4'd2;
                4'b0100: d.subtype = 4'd3;   // ST.B
                4'b0101: d.subtype = 4'd4;
                4'b0110: d.subtype = 4'd5;
                4'b1000: d.subtype = 4'd6;   // LD.BU
                4'b1001: d.subtype = 4'd7;
                default: hit = 1'b0;
            endcase
            is_load    = !ir[24];
            d.unit     = decoder_pkg::UNIT_MEM;
            d.imm      = {{20{imm12[11]}}, imm12};
            d.rj       = ir[`DEC_RJ_LSB +: `DEC_REG_W];
            d.rd       = ir[`DEC_RD_LSB +: `DEC_REG_W];   // Store data for ST
            d.regwrite = is_load;
            d.memread  = is_load;
            d.memwrite = !is_load;
        end
    end

    assign res.hit = hit;
    assign res.dec = d;

    always_comb
    begin
        assert final (!(res.dec.memread && res.dec.memwrite))
            else $error("mem_decode sets both memread and memwrite");
    end

endmodule

//--- verification/decoder_tb.sv
`timescale 1ns/1ps
`include "decoder_params.svh"

module decoder_tb;

    localparam int PERIOD_NS   = 40;
    localparam int N_VECTORS   = 400;
    localparam int WATCHDOG_NS = (N_VECTORS + 20) * PERIOD_NS + 2000;

    localparam logic [6:0] RR_FUNCT [11] = '{7'h20, 7'h22, 7'h24, 7'h25, 7'h28, 7'h29,
                                             7'h2a, 7'h2b, 7'h2e, 7'h2f, 7'h30};
    localparam decoder_pkg::alu_op_e RR_OP [11] = '{decoder_pkg::ALU_ADD,
        decoder_pkg::ALU_SUB, decoder_pkg::ALU_SLT, decoder_pkg::ALU_SLTU,
        decoder_pkg::ALU_NOR, decoder_pkg::ALU_AND, decoder_pkg::ALU_OR, decoder_pkg::ALU_XOR,
        decoder_pkg::ALU_SLL, decoder_pkg::ALU_SRL, decoder_pkg::ALU_SRA};
    localparam logic [3:0] IMM_CODE [6] = '{4'h8, 4'h9, 4'ha, 4'hd, 4'he, 4'hf};
    localparam decoder_pkg::alu_op_e IMM_OP [6] = '{decoder_pkg::ALU_SLT,
        decoder_pkg::ALU_SLTU, decoder_pkg::ALU_ADD, decoder_pkg::ALU_AND,
        decoder_pkg::ALU_OR, decoder_pkg::ALU_XOR};
    localparam logic [3:0] MEM_CODE [8] = '{4'h0, 4'h1, 4'h2, 4'h4, 4'h5, 4'h6, 4'h8, 4'h9};
    // CSR, RDCNT, ERTN, IDLE, DBAR, IBAR, LL, SC, PRELD, TLBSRCH
    localparam logic [31:0] DROPPED [10] = '{32'h0400_0000, 32'h0000_6000, 32'h0648_3800,
        32'h0648_8000, 32'h3872_0000, 32'h3872_8000, 32'h2000_0000, 32'h2100_0000,
        32'h2ac0_0000, 32'h0648_2800};

    typedef struct packed
    {
        logic                 valid;
        decoder_pkg::decode_t dec;
    } expect_t;

    logic                   clk;
    logic                   arst_n;
    logic                   in_valid;
    logic [`DEC_XLEN-1:0]   ir;
    logic [`DEC_XLEN-1:0]   pc;
    logic [`DEC_EXCP_W-1:0] fetch_excp;
    logic                   out_valid;
    decoder_pkg::decode_t   out_dec;

    expect_t exp_q[$];   // One entry in flight
    expect_t cur;
    int      errors;

    tb_clock_gen #(.PERIOD_NS(PERIOD_NS)) u_clock_gen (.clk(clk));

    decoder_top uut
    (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .ir         (ir),
        .pc         (pc),
        .fetch_excp (fetch_excp),
        .out_valid  (out_valid),
        .out_dec    (out_dec)
    );

    task automatic stop_with_failure();
        errors++;
        $display("tests failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        stop_with_failure();
    endtask

    task automatic report_value(input string name, input logic [127:0] exp,
                                input logic [127:0] got);
        $display("ERR %0t %s expected %0h got %0h", $time, name, exp, got);
        stop_with_failure();
    endtask

    task automatic compare_fields(input decoder_pkg::decode_t exp,
                                  input decoder_pkg::decode_t got);
        if (exp.unit != got.unit)
            report_value("out_dec.unit", 128'(exp.unit), 128'(got.unit));
        else if (exp.alu_op != got.alu_op)
            report_value("out_dec.alu_op", 128'(exp.alu_op), 128'(got.alu_op));
        else if (exp.subtype != got.subtype)
            report_value("out_dec.subtype", 128'(exp.subtype), 128'(got.subtype));
        else if (exp.rj != got.rj)
            report_value("out_dec.rj", 128'(exp.rj), 128'(got.rj));
        else if (exp.rk != got.rk)
            report_value("out_dec.rk", 128'(exp.rk), 128'(got.rk));
        else if (exp.rd != got.rd)
            report_value("out_dec.rd", 128'(exp.rd), 128'(got.rd));
        else if (exp.imm != got.imm)
            report_value("out_dec.imm", 128'(exp.imm), 128'(got.imm));
        else if (exp.src1 != got.src1)
            report_value("out_dec.src1", 128'(exp.src1), 128'(got.src1));
        else if (exp.src2 != got.src2)
            report_value("out_dec.src2", 128'(exp.src2), 128'(got.src2));
        else if (exp.regwrite != got.regwrite)
            report_value("out_dec.regwrite", 128'(exp.regwrite), 128'(got.regwrite));
        else if (exp.memread != got.memread)
            report_value("out_dec.memread", 128'(exp.memread), 128'(got.memread));
        else if (exp.memwrite != got.memwrite)
            report_value("out_dec.memwrite", 128'(exp.memwrite), 128'(got.memwrite));
        else if (exp.br_kind != got.br_kind)
            report_value("out_dec.br_kind", 128'(exp.br_kind), 128'(got.br_kind));
        else
            report_value("out_dec.excp_arg", 128'(exp.excp_arg), 128'(got.excp_arg));
    endtask

    function automatic decoder_pkg::decode_t trap_decode(input logic [15:0] code);
        decoder_pkg::decode_t d;
        d          = '0;
        d.unit     = decoder_pkg::UNIT_EXCP;
        d.excp_arg = code;
        return d;
    endfunction

    function automatic logic known_opcode(input logic [5:0] op);
        return op == 6'd0 || op == 6'd5 || op == 6'd7 || op == 6'd10
            || (op >= 6'd19 && op <= 6'd27);
    endfunction

    // Random instruction word and the decode it must give
    task automatic make_vector(output logic [31:0] word, output decoder_pkg::decode_t d);
        int          kind;
        int          sel;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic [11:0] i12;
        logic [19:0] i20;
        logic [15:0] o16;
        logic [25:0] o26;
        logic [5:0]  op;
        kind = $urandom_range(0, 10);
        rd   = 5'($urandom);
        rj   = 5'($urandom);
        rk   = 5'($urandom);
        i12  = 12'($urandom);
        i20  = 20'($urandom);
        o16  = 16'($urandom);
        o26  = 26'($urandom);
        d    = '0;
        case (kind)
            0, 1:   // Three register ALU, MUL and DIV
            begin
                d.rk       = rk;
                d.rj       = rj;
                d.rd       = rd;
                d.regwrite = 1'b1;
                if (kind == 0)
                begin
                    sel      = $urandom_range(0, 10);
                    word     = {10'b0, RR_FUNCT[sel], rk, rj, rd};
                    d.alu_op = RR_OP[sel];
                end
                else
                begin
                    sel = $urandom_range(0, 6);
                    if (sel < 3)
                    begin
                        word      = {10'b0, 5'b01110, 2'(sel), rk, rj, rd};
                        d.unit    = decoder_pkg::UNIT_MUL;
                        d.subtype = 4'(sel);
                    end
                    else
                    begin
                        word      = {10'b0, 5'b10000, 2'(sel - 3), rk, rj, rd};
                        d.unit    = decoder_pkg::UNIT_DIV;
                        d.subtype = 4'(sel - 3);
                    end
                end
            end
            2:   // SLLI.W, SRLI.W, SRAI.W
            begin
                sel        = $urandom_range(0, 2);
                word       = {10'b0001, 2'b00, 2'(sel), 3'b001, rk, rj, rd};
                d.alu_op   = sel == 0 ? decoder_pkg::ALU_SLL
                           : sel == 1 ? decoder_pkg::ALU_SRL : decoder_pkg::ALU_SRA;
                d.imm      = {27'b0, rk};
                d.rj       = rj;
                d.rd       = rd;
                d.src2     = decoder_pkg::SRC2_IMM;
                d.regwrite = 1'b1;
            end
            3:   // SLTI, SLTUI and ADDI.W sign extend, logic ops zero extend
            begin
                sel        = $urandom_range(0, 5);
                word       = {6'b0, IMM_CODE[sel], i12, rj, rd};
                d.alu_op   = IMM_OP[sel];
                d.imm      = sel < 3 ? {{20{i12[11]}}, i12} : {20'b0, i12};
                d.rj       = rj;
                d.rd       = rd;
                d.src2     = decoder_pkg::SRC2_IMM;
                d.regwrite = 1'b1;
            end
            4:   // LU12I.W or PCADDU12I
            begin
                sel        = $urandom_range(0, 1);
                word       = {sel == 1 ? 6'b000111 : 6'b000101, 1'b0, i20, rd};
                d.alu_op   = sel == 1 ? decoder_pkg::ALU_ADD : decoder_pkg::ALU_PASS_B;
                d.src1     = sel == 1 ? decoder_pkg::SRC1_PC : decoder_pkg::SRC1_REG;
                d.imm      = {i20, 12'b0};
                d.rd       = rd;
                d.src2     = decoder_pkg::SRC2_IMM;
                d.regwrite = 1'b1;
            end
            5:   // Loads 0 to 2 and 6 to 7, stores 3 to 5
            begin
                sel        = $urandom_range(0, 7);
                word       = {6'b001010, MEM_CODE[sel], i12, rj, rd};
                d.unit     = decoder_pkg::UNIT_MEM;
                d.subtype  = 4'(sel);
                d.imm      = {{20{i12[11]}}, i12};
                d.rj       = rj;
                d.rd       = rd;
                d.regwrite = sel < 3 || sel > 5;
                d.memread  = sel < 3 || sel > 5;
                d.memwrite = sel >= 3 && sel <= 5;
            end
            6:   // BEQ through BGEU
            begin
                sel       = $urandom_range(0, 5);
                word      = {6'(6'b010110 + sel), o16, rj, rd};
                d.unit    = decoder_pkg::UNIT_BR;
                d.subtype = 4'(sel + 1);
                d.alu_op  = sel < 2 ? decoder_pkg::ALU_SUB
                          : sel < 4 ? decoder_pkg::ALU_SLT : decoder_pkg::ALU_SLTU;
                d.imm     = {{14{o16[15]}}, o16, 2'b00};
                d.rj      = rj;
                d.rd      = rd;
                d.src2    = decoder_pkg::SRC2_RD;
                d.br_kind = decoder_pkg::BR_DIRECT;
            end
            7:   // B or BL
            begin
                sel       = $urandom_range(0, 1);
                word      = {sel == 1 ? 6'b010101 : 6'b010100, o26[15:0], o26[25:16]};
                d.imm     = {{4{o26[25]}}, o26, 2'b00};
                d.unit    = decoder_pkg::UNIT_BR;
                d.br_kind = decoder_pkg::BR_JUMP;
                if (sel == 1)
                begin
                    d.unit     = decoder_pkg::UNIT_LINK;
                    d.subtype  = 4'd1;
                    d.rd       = 5'd1;
                    d.regwrite = 1'b1;
                    d.alu_op   = decoder_pkg::ALU_ADD;
                    d.src1     = decoder_pkg::SRC1_PC;
                    d.src2     = decoder_pkg::SRC2_FOUR;
                    d.br_kind  = decoder_pkg::BR_CALL;
                end
            end
            8:   // JIRL, forced toward RET and CALL forms
            begin
                sel = $urandom_range(0, 2);
                if (sel == 0)
                begin
                    rd  = 5'd0;
                    rj  = 5'd1;
                    o16 = 16'd0;
                end
                else if (sel == 1)
                    rd = 5'd1;
                word       = {6'b010011, o16, rj, rd};
                d.unit     = decoder_pkg::UNIT_LINK;
                d.imm      = {{14{o16[15]}}, o16, 2'b00};
                d.rj       = rj;
                d.rd       = rd;
                d.regwrite = 1'b1;
                d.alu_op   = decoder_pkg::ALU_ADD;
                d.src1     = decoder_pkg::SRC1_PC;
                d.src2     = decoder_pkg::SRC2_FOUR;
                if (rd == 5'd0 && rj == 5'd1 && o16 == 16'd0)
                    d.br_kind = decoder_pkg::BR_RET;
                else if (rd == 5'd1)
                    d.br_kind = decoder_pkg::BR_CALL;
                else
                    d.br_kind = decoder_pkg::BR_INDIRECT;
            end
            9:   // BREAK or SYSCALL
            begin
                sel  = $urandom_range(0, 1);
                word = {10'b0, sel == 1 ? 7'b1010110 : 7'b1010100, 15'($urandom)};
                d    = trap_decode(sel == 1 ? `DEC_EXCP_SYS : `DEC_EXCP_BRK);
            end
            default:
            begin
                if ($urandom_range(0, 1) == 0)
                    word = DROPPED[$urandom_range(0, 9)] | {27'b0, rd};
                else
                begin
                    do
                        op = 6'($urandom);
                    while (known_opcode(op));
                    word = {op, 26'($urandom)};
                end
                d = trap_decode(`DEC_EXCP_INE);
            end
        endcase
    endtask

    task automatic drive_cycle(input logic valid, input logic [31:0] word,
                               input logic [31:0] addr, input logic [15:0] fe,
                               input decoder_pkg::decode_t exp, input logic rst_level);
        expect_t e;
        @(posedge clk);
        #2;
        arst_n     = rst_level;
        cur        = exp_q.pop_front();
        e.valid    = valid & rst_level;
        e.dec      = e.valid ? exp : '0;
        exp_q.push_back(e);
        in_valid   = valid;
        ir         = word;
        pc         = addr;
        fetch_excp = fe;
    endtask

    a_reset_valid: assert property (@(negedge clk) !arst_n |-> !out_valid)
        else report_failure("out_valid is high while reset is held");

    a_reset_dec: assert property (@(negedge clk) !arst_n |-> out_dec == '0)
        else report_failure("out_dec is not zero while reset is held");

    a_valid: assert property (@(negedge clk) disable iff (!arst_n) out_valid == cur.valid)
        else report_value("out_valid", 128'(cur.valid), 128'(out_valid));

    a_dec: assert property (@(negedge clk) disable iff (!arst_n) out_dec == cur.dec)
        else compare_fields(cur.dec, out_dec);

    initial
    begin
        #(WATCHDOG_NS);
        report_failure("watchdog expired before the stimulus finished");
    end

    initial
    begin
        logic [31:0]          word;
        logic [31:0]          addr;
        logic [15:0]          fe;
        decoder_pkg::decode_t exp;
        int                   n;
        arst_n     = 1'b0;
        in_valid   = 1'b0;
        ir         = '0;
        pc         = '0;
        fetch_excp = '0;
        cur        = '0;
        errors     = 0;
        exp_q.push_back('0);
        void'($urandom(32'h9b0a));

        // Strobes during reset must not leave the stage
        for (n = 0; n < 10; n++)
        begin
            make_vector(word, exp);
            drive_cycle(n < 9, word, 32'h0, 16'h0, exp, 1'b0);
        end

        for (n = 0; n < N_VECTORS; n++)
        begin
            make_vector(word, exp);
            addr = {30'($urandom), 2'b00};
            fe   = {1'b0, 15'($urandom)};
            if ($urandom_range(0, 7) == 0)
                addr[1:0] = 2'($urandom_range(1, 3));
            if ($urandom_range(0, 7) == 0)
                fe[15] = 1'b1;
            if (fe[15])
                exp = trap_decode({1'b0, fe[14:0]});
            else if (addr[1:0] != 2'b00)
                exp = trap_decode(`DEC_EXCP_ADEF);
            drive_cycle($urandom_range(0, 3) != 0, word, addr, fe, exp, 1'b1);
        end

        drive_cycle(1'b0, 32'h0, 32'h0, 16'h0, '0, 1'b1);
        drive_cycle(1'b0, 32'h0, 32'h0, 16'h0, '0, 1'b1);
        @(negedge clk);
        #1;
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen
#(
    parameter int PERIOD_NS = 40
)
(
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule
